// File: verilog.f
+incdir+include
rtl/emailbox_pkg.sv
rtl/emesh_write_decode.sv
rtl/mailbox_status_fsm.sv
rtl/mailbox_ptr_counter.sv
rtl/mailbox_storage.sv
rtl/mi_read_port.sv
rtl/emailbox.sv
verif/emailbox_properties.sv
verif/emailbox_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module emailbox_tb -o emailbox_sim

out=$(./obj_dir/emailbox_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
   exit 0
else
   exit 1
fi

// File: verif/emailbox_tb.sv
`timescale 1ns/1ps
`default_nettype none

module emailbox_tb;

   import emailbox_pkg::*;

   localparam int       DEPTH       = 4;
   localparam link_id_t LINK_ID     = 12'h0a5;
   localparam int       CLK_PERIOD  = 8;                          // ns
   localparam int       N_RANDOM    = 200;                        // random steps of one cycle each
   localparam int       TEST_CYCLES = 22 + 3 * DEPTH + N_RANDOM;  // reset plus directed tests
   localparam int       MARGIN      = 100;

   logic          rd_clk;
   logic          rst_n;
   logic          emesh_access;
   emesh_packet_t emesh_packet;
   logic          mi_en;
   logic          mi_we;
   mi_addr_t      mi_addr;
   mbox_data_t    mi_dout;
   logic          mailbox_full;
   logic          mailbox_not_empty;

   mbox_data_t model_q[$];  // expected contents with head first
   string      test_name;

   emailbox #(
      .DEPTH   (DEPTH),
      .LINK_ID (LINK_ID)
   ) emailbox_inst (
      .rd_clk            (rd_clk),
      .rst_n             (rst_n),
      .emesh_access      (emesh_access),
      .emesh_packet      (emesh_packet),
      .mi_en             (mi_en),
      .mi_we             (mi_we),
      .mi_addr           (mi_addr),
      .mi_dout           (mi_dout),
      .mailbox_full      (mailbox_full),
      .mailbox_not_empty (mailbox_not_empty)
   );

   initial rd_clk = 1'b0;
   always #(CLK_PERIOD / 2) rd_clk = ~rd_clk;

   // one edge and past it so outputs are settled
   task automatic step();
      @(posedge rd_clk);
      #1;
   endtask

   task automatic check(input string what, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (actual !== expected) begin
         $display("MISMATCH %s %s: expected %h actual %h", test_name, what, expected, actual);
         $display("Test failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // flags follow the model count
   task automatic check_flags();
      check("mailbox_full", 64'(model_q.size() == DEPTH), 64'(mailbox_full));
      check("mailbox_not_empty", 64'(model_q.size() != 0), 64'(mailbox_not_empty));
   endtask

   // id [31:20], group [10:8], index [7:2]
   function automatic emesh_addr_t mesh_addr(input link_id_t id, input logic [2:0] group,
                                             input reg_idx_t idx);
      return {id, 9'h000, group, idx, 2'b00};
   endfunction

   task automatic send_packet(input mbox_data_t data, input emesh_addr_t addr, input logic wr);
      emesh_access = 1'b1;
      emesh_packet = {data, addr, 6'h00, wr, 1'b0};  // payload, address, write flag
      step();
      emesh_access = 1'b0;
      emesh_packet = '0;
   endtask

   task automatic push_valid(input mbox_data_t data);
      if (model_q.size() < DEPTH) begin
         model_q.push_back(data);  // dropped when full
      end
      send_packet(data, mesh_addr(LINK_ID, MBOX_GROUP, MAILBOXLO), 1'b1);
      check_flags();
   endtask

   task automatic push_invalid(input int kind, input mbox_data_t data);
      case (kind)
         0:       send_packet(data, mesh_addr(LINK_ID ^ 12'h001, MBOX_GROUP, MAILBOXLO), 1'b1);
         1:       send_packet(data, mesh_addr(LINK_ID, 3'h2, MAILBOXLO), 1'b1);  // other group
         2:       send_packet(data, mesh_addr(LINK_ID, MBOX_GROUP, MAILBOXHI), 1'b1);
         default: send_packet(data, mesh_addr(LINK_ID, MBOX_GROUP, MAILBOXLO), 1'b0);  // read
      endcase
      check_flags();
   endtask

   task automatic host_access(input reg_idx_t idx, input logic we, output mbox_data_t data);
      mi_en   = 1'b1;
      mi_we   = we;
      mi_addr = {idx, 2'b00};
      step();
      mi_en   = 1'b0;
      mi_we   = 1'b0;
      mi_addr = '0;
      data    = mi_dout;  // loaded at that edge
   endtask

   task automatic read_lo();
      mbox_data_t d;
      host_access(MAILBOXLO, 1'b0, d);
      if (model_q.size() != 0) check("lo read", model_q[0], d);
      check_flags();
   endtask

   task automatic read_hi();
      mbox_data_t d;
      mbox_data_t head;
      host_access(MAILBOXHI, 1'b0, d);
      if (model_q.size() != 0) begin
         head = model_q.pop_front();
         check("hi read", {head[63:32], head[63:32]}, d);  // upper word twice
      end
      check_flags();
   endtask

   task automatic test_reset_single();
      test_name = "reset_single";
      check_flags();
      check("mi_dout after reset", 64'h0, mi_dout);
      push_valid(64'h1122_3344_5566_7788);
      read_lo();
      read_hi();  // leaves it empty
   endtask

   task automatic test_filter();
      test_name = "filter";
      for (int k = 0; k < 4; k++) begin
         push_invalid(k, {$urandom, $urandom});
      end
   endtask

   task automatic test_fill_drain();
      test_name = "fill_drain";
      for (int i = 0; i <= DEPTH; i++) begin
         push_valid({32'hc0de_0000 + 32'(i), 32'h0000_1000 + 32'(i)});  // last one overflows
      end
      for (int i = 0; i < DEPTH; i++) begin
         read_lo();
         read_hi();  // full clears on the first
      end
   endtask

   task automatic test_read_decode();
      mbox_data_t d;
      test_name = "read_decode";
      push_valid(64'hdead_beef_0bad_f00d);
      push_valid(64'h0123_4567_89ab_cdef);
      repeat (3) read_lo();  // no pop
      host_access(6'h05, 1'b0, d);
      check("unmapped read", 64'h0, d);
      host_access(MAILBOXHI, 1'b1, d);  // host write is ignored
      check("host write dout", 64'h0, d);
      check_flags();
      read_lo();
      read_hi();
      read_hi();
   endtask

   task automatic test_random();
      test_name = "random";
      for (int n = 0; n < N_RANDOM; n++) begin
         case ($urandom_range(0, 9))
            0, 1, 2, 3: push_valid({$urandom, $urandom});  // biased so full is reached
            4, 5:       push_invalid(int'($urandom_range(0, 3)), {$urandom, $urandom});
            6, 7:       read_lo();
            default:    read_hi();
         endcase
      end
   endtask

   initial begin
      #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
      $display("watchdog expired after %0d cycles, tests did not finish", TEST_CYCLES + MARGIN);
      $display("Test failed");
      $fatal(1, "timeout");
   end

   initial begin
      rst_n        = 1'b0;
      emesh_access = 1'b0;
      emesh_packet = '0;
      mi_en        = 1'b0;
      mi_we        = 1'b0;
      mi_addr      = '0;
      void'($urandom(32'h316a0371));
      repeat (2) @(posedge rd_clk);  // reset over two edges
      #1 rst_n = 1'b1;
      test_reset_single();
      test_filter();
      test_fill_drain();
      test_read_decode();
      test_random();
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/emailbox_properties.sv
`timescale 1ns/1ps
`default_nettype none

module emailbox_properties #(
   parameter int DEPTH = 16,                 // entries, power of two
   localparam int CNT_W = $clog2(DEPTH) + 1  // counts 0..DEPTH
) (
   input wire logic                     rd_clk,
   input wire logic                     rst_n,
   input wire logic                     mi_en,
   input wire logic                     mi_we,
   input wire emailbox_pkg::mbox_data_t mi_dout,
   input wire logic                     push_req,           // decoded mesh write
   input wire logic                     pop_req,            // host HI read
   input wire logic                     mailbox_full,
   input wire logic                     mailbox_not_empty,
   input wire logic         [CNT_W-1:0] count               // internal occupancy
);

   // entries held means at least one flag up
   flags_track_count: assert property (@(posedge rd_clk) disable iff (!rst_n)
      (count != '0) |-> (mailbox_full || mailbox_not_empty))
      else $error("both flags low while the mailbox holds entries");

   // read data clears after an idle cycle
   dout_idle_zero: assert property (@(posedge rd_clk) disable iff (!rst_n)
      !(mi_en && !mi_we) |=> (mi_dout == '0))
      else $error("mi_dout nonzero one cycle after a cycle without a read");

   // overflow drops the packet
   full_push_dropped: assert property (@(posedge rd_clk) disable iff (!rst_n)
      (push_req && mailbox_full && !pop_req) |=> (count == $past(count)))
      else $error("push while full changed the entry count");

endmodule

bind emailbox emailbox_properties #(
   .DEPTH (DEPTH)
) emailbox_properties_inst (
   .rd_clk            (rd_clk),
   .rst_n             (rst_n),
   .mi_en             (mi_en),
   .mi_we             (mi_we),
   .mi_dout           (mi_dout),
   .push_req          (push_req),
   .pop_req           (pop_req),
   .mailbox_full      (mailbox_full),
   .mailbox_not_empty (mailbox_not_empty),
   .count             (count)
);

`default_nettype wire

// File: rtl/emailbox.sv
`timescale 1ns/1ps
`default_nettype none

module emailbox #(
   parameter int                     DEPTH   = 16,      // queue entries
   parameter emailbox_pkg::link_id_t LINK_ID = 12'h000  // mesh id of this link
) (
   input  wire logic                        rd_clk,
   input  wire logic                        rst_n,              // sync, active low
   input  wire logic                        emesh_access,       // packet strobe
   input  wire emailbox_pkg::emesh_packet_t emesh_packet,       // incoming packet
   input  wire logic                        mi_en,              // host enable
   input  wire logic                        mi_we,              // host write
   input  wire emailbox_pkg::mi_addr_t      mi_addr,            // host address
   output emailbox_pkg::mbox_data_t         mi_dout,            // host read data
   output logic                             mailbox_full,       // status
   output logic                             mailbox_not_empty   // interrupt
);

   import emailbox_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = PTR_W + 1;

   logic             push_req;   // decoded write
   mbox_data_t       push_data;  // its payload
   logic             pop_req;    // HI read
   logic             push_ok;    // granted push
   logic             pop_ok;     // granted pop
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;      // occupancy
   mbox_data_t       head_data;  // oldest entry

   // mesh side decode
   emesh_write_decode #(
      .LINK_ID (LINK_ID)
   ) emesh_write_decode_inst (
      .emesh_access (emesh_access),
      .emesh_packet (emesh_packet),
      .push_req     (push_req),
      .push_data    (push_data)
   );

   // full/empty decisions live here only
   mailbox_status_fsm #(
      .DEPTH (DEPTH)
   ) mailbox_status_fsm_inst (
      .rd_clk            (rd_clk),
      .rst_n             (rst_n),
      .push_req          (push_req),
      .pop_req           (pop_req),
      .count             (count),
      .push_ok           (push_ok),
      .pop_ok            (pop_ok),
      .mailbox_full      (mailbox_full),
      .mailbox_not_empty (mailbox_not_empty)
   );

   mailbox_ptr_counter #(
      .DEPTH (DEPTH)
   ) mailbox_ptr_counter_inst (
      .rd_clk  (rd_clk),
      .rst_n   (rst_n),
      .push_ok (push_ok),
      .pop_ok  (pop_ok),
      .wr_ptr  (wr_ptr),
      .rd_ptr  (rd_ptr),
      .count   (count)
   );

   mailbox_storage #(
      .DEPTH (DEPTH)
   ) mailbox_storage_inst (
      .rd_clk    (rd_clk),
      .push_ok   (push_ok),
      .wr_ptr    (wr_ptr),
      .push_data (push_data),
      .rd_ptr    (rd_ptr),
      .head_data (head_data)
   );

   // host register port
   mi_read_port mi_read_port_inst (
      .rd_clk    (rd_clk),
      .rst_n     (rst_n),
      .mi_en     (mi_en),
      .mi_we     (mi_we),
      .mi_addr   (mi_addr),
      .head_data (head_data),
      .mi_dout   (mi_dout),
      .pop_req   (pop_req)
   );

endmodule

`default_nettype wire

// File: rtl/mi_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module mi_read_port (
   input  wire logic                     rd_clk,
   input  wire logic                     rst_n,      // sync, active low
   input  wire logic                     mi_en,      // host access
   input  wire logic                     mi_we,      // host write, ignored
   input  wire emailbox_pkg::mi_addr_t   mi_addr,    // host byte address
   input  wire emailbox_pkg::mbox_data_t head_data,  // current head entry
   output emailbox_pkg::mbox_data_t      mi_dout,    // registered read data
   output logic                          pop_req     // HI read pops
);

   import emailbox_pkg::*;

   logic     mi_rd;    // read cycle
   reg_idx_t reg_idx;  // decoded register

   assign mi_rd   = mi_en & ~mi_we;
   assign reg_idx = mi_addr[7:2];  // word index

   // reading the high word retires the entry
   assign pop_req = mi_rd & (reg_idx == MAILBOXHI);

   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         mi_dout <= '0;
      end else if (mi_rd) begin
         case (reg_idx)
            MAILBOXLO: mi_dout <= head_data;                          // whole entry
            MAILBOXHI: mi_dout <= {head_data[63:32], head_data[63:32]}; // upper word twice
            default:   mi_dout <= '0;                                 // unmapped index
         endcase
      end else begin
         mi_dout <= '0;  // zero when idle
      end
   end

endmodule

`default_nettype wire

// File: rtl/mailbox_storage.sv
`timescale 1ns/1ps
`default_nettype none

module mailbox_storage #(
   parameter int DEPTH = 16,              // entries, power of two
   localparam int PTR_W = $clog2(DEPTH)   // pointer width
) (
   input  wire logic                     rd_clk,
   input  wire logic                     push_ok,    // write enable
   input  wire logic         [PTR_W-1:0] wr_ptr,     // write slot
   input  wire emailbox_pkg::mbox_data_t push_data,  // entry to store
   input  wire logic         [PTR_W-1:0] rd_ptr,     // head slot
   output emailbox_pkg::mbox_data_t      head_data   // oldest entry
);

   import emailbox_pkg::*;

   mbox_data_t mem [DEPTH];  // entry array, contents undefined until written

   always_ff @(posedge rd_clk) begin
      if (push_ok) begin
         mem[wr_ptr] <= push_data;  // stored at the strobe edge
      end
   end

   // async head read, so a pop shows the next entry right away
   assign head_data = mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/mailbox_ptr_counter.sv
`timescale 1ns/1ps
`default_nettype none

module mailbox_ptr_counter #(
   parameter int DEPTH = 16,               // entries, power of two
   localparam int PTR_W = $clog2(DEPTH),   // pointer width
   localparam int CNT_W = PTR_W + 1        // count up to DEPTH
) (
   input  wire logic             rd_clk,
   input  wire logic             rst_n,    // sync, active low
   input  wire logic             push_ok,  // granted write
   input  wire logic             pop_ok,   // granted read
   output logic      [PTR_W-1:0] wr_ptr,   // next free slot
   output logic      [PTR_W-1:0] rd_ptr,   // head slot
   output logic      [CNT_W-1:0] count     // entries held
);

   // write pointer, wraps at DEPTH
   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (push_ok) begin
         wr_ptr <= wr_ptr + 1'b1;  // power-of-two wrap
      end
   end

   // read pointer, wraps at DEPTH
   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         rd_ptr <= '0;
      end else if (pop_ok) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // occupancy
   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         count <= '0;
      end else begin
         case ({push_ok, pop_ok})
            2'b10:   count <= count + 1'b1;  // push only
            2'b01:   count <= count - 1'b1;  // pop only
            default: count <= count;         // idle or both at once
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/mailbox_status_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mailbox_status_fsm #(
   parameter int DEPTH = 16,                 // entries, power of two
   localparam int CNT_W = $clog2(DEPTH) + 1  // counts 0..DEPTH
) (
   input  wire logic             rd_clk,
   input  wire logic             rst_n,              // sync, active low
   input  wire logic             push_req,           // decoded mesh write
   input  wire logic             pop_req,            // host HI read
   input  wire logic [CNT_W-1:0] count,              // current occupancy
   output logic                  push_ok,            // push granted
   output logic                  pop_ok,             // pop granted
   output logic                  mailbox_full,       // status level
   output logic                  mailbox_not_empty   // level interrupt
);

   import emailbox_pkg::*;

   mbox_state_t      state;       // registered occupancy class
   mbox_state_t      state_nxt;
   logic [CNT_W-1:0] count_nxt;   // occupancy after this edge

   // grants: drop pushes when full, ignore pops when empty
   assign push_ok = push_req & (state != MBOX_FULL);
   assign pop_ok  = pop_req & (state != MBOX_EMPTY);

   always_comb begin
      count_nxt = count;
      if (push_ok && !pop_ok) begin
         count_nxt = count + 1'b1;  // net gain
      end else if (pop_ok && !push_ok) begin
         count_nxt = count - 1'b1;  // net loss
      end
      if (count_nxt == '0) begin
         state_nxt = MBOX_EMPTY;
      end else if (count_nxt == CNT_W'(DEPTH)) begin
         state_nxt = MBOX_FULL;
      end else begin
         state_nxt = MBOX_ACTIVE;
      end
   end

   always_ff @(posedge rd_clk) begin
      if (!rst_n) begin
         state <= MBOX_EMPTY;
      end else begin
         state <= state_nxt;  // flags follow one edge after the strobe
      end
   end

   // flags straight off the state register
   assign mailbox_full      = (state == MBOX_FULL);
   assign mailbox_not_empty = (state != MBOX_EMPTY);

endmodule

`default_nettype wire

// File: rtl/emesh_write_decode.sv
`timescale 1ns/1ps
`default_nettype none

module emesh_write_decode #(
   parameter emailbox_pkg::link_id_t LINK_ID = 12'h000  // this endpoint's mesh id
) (
   input  wire logic                        emesh_access,  // packet strobe
   input  wire emailbox_pkg::emesh_packet_t emesh_packet,  // raw transaction
   output logic                             push_req,      // qualified mailbox write
   output emailbox_pkg::mbox_data_t         push_data      // payload to queue
);

   import emailbox_pkg::*;

   emesh_addr_t emesh_addr;  // destination address
   logic        is_write;    // write flag from the packet
   logic        id_hit;      // addressed to this link
   logic        group_hit;   // mailbox register group
   reg_idx_t    reg_idx;     // target register

   assign emesh_addr = emesh_packet[39:8];   // address field
   assign is_write   = emesh_packet[1];      // reads never queue
   assign push_data  = emesh_packet[103:40]; // 64-bit payload

   assign id_hit    = (emesh_addr[31:20] == LINK_ID);
   assign group_hit = (emesh_addr[10:8] == MBOX_GROUP);
   assign reg_idx   = emesh_addr[7:2];

   // only writes to MAILBOXLO enter the queue
   assign push_req = emesh_access &
                     is_write &
                     id_hit &
                     group_hit &
                     (reg_idx == MAILBOXLO);

endmodule

`default_nettype wire

// File: rtl/emailbox_pkg.sv
`default_nettype none

package emailbox_pkg;

   // packet layout: [1] write, [39:8] address, [103:40] payload
   typedef logic [103:0] emesh_packet_t;  // full mesh transaction
   typedef logic [31:0]  emesh_addr_t;    // mesh address field
   typedef logic [63:0]  mbox_data_t;     // one queued entry
   typedef logic [11:0]  link_id_t;       // compared with addr[31:20]

   // host side
   typedef logic [7:0]   mi_addr_t;       // byte address, [7:2] is the index
   typedef logic [5:0]   reg_idx_t;       // register index

   // occupancy tracking
   typedef enum logic [1:0] {
      MBOX_EMPTY  = 2'b00,  // nothing queued
      MBOX_ACTIVE = 2'b01,  // some entries, room left
      MBOX_FULL   = 2'b10   // DEPTH entries held
   } mbox_state_t;

   // register map constants
   `include "emailbox_regmap.svh"

endpackage

`default_nettype wire

// File: include/emailbox_regmap.svh
`ifndef EMAILBOX_REGMAP_SVH
`define EMAILBOX_REGMAP_SVH

// mailbox register group, matched on addr[10:8]
localparam logic [2:0] MBOX_GROUP = 3'h3;

// register indices, addr[7:2]
localparam logic [5:0] MAILBOXLO  = 6'h08;  // low word, full entry on read
localparam logic [5:0] MAILBOXHI  = 6'h09;  // high word, pops on read

`endif
